//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rob_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- commit_unit.sv
// In-order commit FSM with jump resolution and the architectural register file
`timescale 1ns/1ps

module commit_unit (
  input  logic                clock,
  input  logic                reset,
  // Head entry from the reorder buffer
  input  logic                head_valid,
  input  rob_pkg::addr_t      head_address,
  input  rob_pkg::arch_reg_t  head_dest,
  input  logic                head_writes,
  input  logic                head_jumps,
  input  rob_pkg::word_t      head_result,
  input  rob_pkg::addr_t      head_jmp_address,
  output logic                head_pop,
  // Retire report
  output logic                commit_valid,
  output rob_pkg::addr_t      commit_address,
  output rob_pkg::arch_reg_t  commit_dest,
  output rob_pkg::word_t      commit_result,
  // Redirect on a taken jump
  output logic                jmp_write,
  output rob_pkg::addr_t      jmp_address,
  // Speculation control to dispatch and reorder buffer
  output logic                delete_tag,
  output logic                clear_tag,
  // Register read port
  input  rob_pkg::arch_reg_t  rf_addr,
  output rob_pkg::word_t      rf_data
);

  import rob_pkg::*;

  commit_state_e state;

  // Entry taken from the head
  addr_t     r_address;
  arch_reg_t r_dest;
  logic      r_writes;
  logic      r_jumps;
  word_t     r_result;
  addr_t     r_jmp_address;

  word_t regs [ARCH_REGS];

  logic retire;
  // Predict-not-taken missed
  logic mispredict;

  assign retire     = state == RETIRE;
  assign head_pop   = state == IDLE && head_valid;
  assign mispredict = r_jmp_address != r_address + INSTR_BYTES;

  assign commit_valid   = retire;
  assign commit_address = r_address;
  assign commit_dest    = r_dest;
  assign commit_result  = r_result;

  // Jump outcome pulses for the single RETIRE cycle
  assign jmp_write   = retire && r_jumps && mispredict;
  assign jmp_address = r_jmp_address;
  assign delete_tag  = retire && r_jumps && mispredict;
  assign clear_tag   = retire && r_jumps && !mispredict;

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= IDLE;
      r_address     <= '0;
      r_dest        <= '0;
      r_writes      <= 1'b0;
      r_jumps       <= 1'b0;
      r_result      <= '0;
      r_jmp_address <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (head_valid) begin
            r_address     <= head_address;
            r_dest        <= head_dest;
            r_writes      <= head_writes;
            r_jumps       <= head_jumps;
            r_result      <= head_result;
            r_jmp_address <= head_jmp_address;
            state         <= RETIRE;
          end
        end
        RETIRE:  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Write-back skips x0
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (retire && r_writes && r_dest != '0) begin
      regs[r_dest] <= r_result;
    end
  end

  assign rf_data = regs[rf_addr];

  // Wrong-path entries left behind a taken jump never reach commit
  a_flush_no_head: assert property (@(posedge clock) disable iff (reset)
    delete_tag |=> !head_valid);

endmodule

//--- flist.f
rob_pkg.sv
instr_dispatch.sv
reorder_buffer.sv
commit_unit.sv
rob_core_top.sv
tb_rob_core.sv

//--- instr_dispatch.sv
// Dispatch pipeline register with speculation marking and jump stall
`timescale 1ns/1ps

module instr_dispatch (
  input  logic                clock,
  input  logic                reset,
  // Decoded instruction stream
  input  logic                in_valid,
  input  rob_pkg::addr_t      in_address,
  input  rob_pkg::arch_reg_t  in_dest,
  input  logic                in_writes,
  input  logic                in_jumps,
  output logic                in_ready,
  // Towards the reorder buffer
  output logic                dsp_valid,
  output rob_pkg::addr_t      dsp_address,
  output rob_pkg::arch_reg_t  dsp_dest,
  output logic                dsp_writes,
  output logic                dsp_jumps,
  output logic                dsp_spec,
  input  logic                dsp_ready,
  // Jump resolution from commit
  input  logic                delete_tag,
  input  logic                clear_tag
);

  // A jump is in flight and not yet resolved
  logic jump_pending;
  // Register is empty or drains this cycle
  logic has_space;
  logic accept;

  assign has_space = !dsp_valid || dsp_ready;

  // Flush cycle accepts nothing, the offered instruction waits one cycle
  // Second jump waits for the first to resolve
  assign in_ready = in_valid && has_space && !delete_tag && !(in_jumps && jump_pending);
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      dsp_valid    <= 1'b0;
      dsp_address  <= '0;
      dsp_dest     <= '0;
      dsp_writes   <= 1'b0;
      dsp_jumps    <= 1'b0;
      dsp_spec     <= 1'b0;
      jump_pending <= 1'b0;
    end else begin
      if (delete_tag) begin
        // Held instruction is on the wrong path
        dsp_valid <= 1'b0;
      end else if (accept) begin
        dsp_valid   <= 1'b1;
        dsp_address <= in_address;
        dsp_dest    <= in_dest;
        dsp_writes  <= in_writes;
        dsp_jumps   <= in_jumps;
        // Behind an open jump, unless it resolves as fall-through now
        dsp_spec    <= jump_pending && !clear_tag;
      end else if (dsp_ready) begin
        dsp_valid <= 1'b0;
      end

      // Fall-through resolution also covers a held entry
      if (clear_tag && !accept) begin
        dsp_spec <= 1'b0;
      end

      // Pending jump tracking
      if (delete_tag || clear_tag) begin
        jump_pending <= 1'b0;
      end else if (accept && in_jumps) begin
        jump_pending <= 1'b1;
      end
    end
  end

  // The jump stall keeps a jump from ever being speculative
  a_no_spec_jump: assert property (@(posedge clock) disable iff (reset)
    dsp_valid |-> !(dsp_jumps && dsp_spec));

endmodule

//--- reorder_buffer.sv
// Reorder buffer entry store with allocation, tagged completion, flush and head pop
`timescale 1ns/1ps

module reorder_buffer #(
  parameter int SIZE = 16
) (
  input  logic                clock,
  input  logic                reset,
  // Allocation from dispatch
  input  logic                dsp_valid,
  input  rob_pkg::addr_t      dsp_address,
  input  rob_pkg::arch_reg_t  dsp_dest,
  input  logic                dsp_writes,
  input  logic                dsp_jumps,
  input  logic                dsp_spec,
  output logic                dsp_ready,
  // Tag handed to the execution side
  output logic                issue_valid,
  output rob_pkg::rob_tag_t   issue_tag,
  // Completion bus
  input  logic                cdb_valid,
  input  rob_pkg::rob_tag_t   cdb_tag,
  input  rob_pkg::word_t      cdb_result,
  input  rob_pkg::addr_t      cdb_jmp_address,
  // Head entry towards commit
  output logic                head_valid,
  output rob_pkg::addr_t      head_address,
  output rob_pkg::arch_reg_t  head_dest,
  output logic                head_writes,
  output logic                head_jumps,
  output rob_pkg::word_t      head_result,
  output rob_pkg::addr_t      head_jmp_address,
  input  logic                head_pop,
  // Jump resolution
  input  logic                delete_tag,
  input  logic                clear_tag
);

  import rob_pkg::*;

  // Pointer wrap for power-of-two depths below the tag range
  localparam rob_tag_t PTR_MASK = rob_tag_t'(SIZE - 1);

  generate
    if (SIZE < 2 || SIZE > 2 ** ROB_TAG_W || (SIZE & (SIZE - 1)) != 0) begin : g_bad_size
      $error("reorder_buffer SIZE must be a power of two within the tag range");
    end
  endgenerate

  // Entry fields
  addr_t         ent_address     [SIZE];
  arch_reg_t     ent_dest        [SIZE];
  logic          ent_writes      [SIZE];
  logic          ent_jumps       [SIZE];
  logic          ent_spec        [SIZE];
  word_t         ent_result      [SIZE];
  addr_t         ent_jmp_address [SIZE];
  entry_status_e ent_status      [SIZE];

  rob_tag_t           head_ptr;
  rob_tag_t           tail_ptr;
  logic [ROB_TAG_W:0] count;
  logic               empty;
  logic               alloc;
  logic               discard;
  logic               pop;
  // Distance of a completion tag from the head
  rob_tag_t           cdb_offset;

  assign empty     = count == '0;
  assign dsp_ready = count != SIZE[ROB_TAG_W:0];
  assign alloc     = dsp_valid && dsp_ready;

  // Tag goes out in the allocation cycle
  assign issue_valid = alloc;
  assign issue_tag   = tail_ptr;

  // Head view, only completed entries are offered
  assign head_valid       = !empty && ent_status[head_ptr] == COMPLETED;
  assign head_address     = ent_address[head_ptr];
  assign head_dest        = ent_dest[head_ptr];
  assign head_writes      = ent_writes[head_ptr];
  assign head_jumps       = ent_jumps[head_ptr];
  assign head_result      = ent_result[head_ptr];
  assign head_jmp_address = ent_jmp_address[head_ptr];

  // Flushed entries leave one per cycle without reaching commit
  assign discard = !empty && ent_status[head_ptr] == IGNORE;
  assign pop     = (head_pop && head_valid) || discard;

  assign cdb_offset = (cdb_tag - head_ptr) & PTR_MASK;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < SIZE; i++) begin
        ent_status[i] <= WAITING;
        ent_spec[i]   <= 1'b0;
      end
    end else begin
      // Results arrive out of order by tag
      if (cdb_valid && ent_status[cdb_tag] == WAITING) begin
        ent_result[cdb_tag]      <= cdb_result;
        ent_jmp_address[cdb_tag] <= cdb_jmp_address;
        ent_status[cdb_tag]      <= COMPLETED;
      end

      // Taken jump kills the speculative tail, fall-through keeps it
      for (int i = 0; i < SIZE; i++) begin
        if (delete_tag && ent_spec[i]) begin
          ent_status[i] <= IGNORE;
          ent_spec[i]   <= 1'b0;
        end else if (clear_tag) begin
          ent_spec[i] <= 1'b0;
        end
      end

      // New entry last so it wins over stale marks on the free slot
      if (alloc) begin
        ent_address[tail_ptr] <= dsp_address;
        ent_dest[tail_ptr]    <= dsp_dest;
        ent_writes[tail_ptr]  <= dsp_writes;
        ent_jumps[tail_ptr]   <= dsp_jumps;
        ent_spec[tail_ptr]    <= dsp_spec && !delete_tag && !clear_tag;
        ent_status[tail_ptr]  <= (dsp_spec && delete_tag) ? IGNORE : WAITING;
      end
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (alloc) begin
        tail_ptr <= (tail_ptr + 1'b1) & PTR_MASK;
      end
      if (pop) begin
        head_ptr <= (head_ptr + 1'b1) & PTR_MASK;
      end
      case ({alloc, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Full buffer leaves the dispatch entry untouched until a slot frees
  a_full_holds: assert property (@(posedge clock) disable iff (reset)
    dsp_valid && !dsp_ready && !delete_tag |=> dsp_valid && $stable(dsp_address));

  // Commit only takes a completed entry from a non-empty buffer
  a_pop_nonempty: assert property (@(posedge clock) disable iff (reset)
    head_pop |-> !empty && ent_status[head_ptr] == COMPLETED);

  // Completions only target allocated entries
  a_cdb_in_range: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> {1'b0, cdb_offset} < count);

endmodule

//--- rob_core_top.sv
// Retirement subsystem top with dispatch, reorder buffer and commit unit
`timescale 1ns/1ps

module rob_core_top #(
  parameter int SIZE = 16
) (
  input  logic                clock,
  input  logic                reset,
  // Decoded instruction stream
  input  logic                in_valid,
  input  rob_pkg::addr_t      in_address,
  input  rob_pkg::arch_reg_t  in_dest,
  input  logic                in_writes,
  input  logic                in_jumps,
  output logic                in_ready,
  // Allocated tag
  output logic                issue_valid,
  output rob_pkg::rob_tag_t   issue_tag,
  // Completion bus
  input  logic                cdb_valid,
  input  rob_pkg::rob_tag_t   cdb_tag,
  input  rob_pkg::word_t      cdb_result,
  input  rob_pkg::addr_t      cdb_jmp_address,
  // Retire report
  output logic                commit_valid,
  output rob_pkg::addr_t      commit_address,
  output rob_pkg::arch_reg_t  commit_dest,
  output rob_pkg::word_t      commit_result,
  // Redirect
  output logic                jmp_write,
  output rob_pkg::addr_t      jmp_address,
  // Register read port
  input  rob_pkg::arch_reg_t  rf_addr,
  output rob_pkg::word_t      rf_data
);

  import rob_pkg::*;

  // Dispatch to reorder buffer
  logic      dsp_valid;
  addr_t     dsp_address;
  arch_reg_t dsp_dest;
  logic      dsp_writes;
  logic      dsp_jumps;
  logic      dsp_spec;
  logic      dsp_ready;

  // Reorder buffer head to commit
  logic      head_valid;
  addr_t     head_address;
  arch_reg_t head_dest;
  logic      head_writes;
  logic      head_jumps;
  word_t     head_result;
  addr_t     head_jmp_address;
  logic      head_pop;

  // Jump resolution fan-out
  logic      delete_tag;
  logic      clear_tag;

  instr_dispatch u_dispatch (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_address (in_address),
    .in_dest    (in_dest),
    .in_writes  (in_writes),
    .in_jumps   (in_jumps),
    .in_ready   (in_ready),
    .dsp_valid  (dsp_valid),
    .dsp_address(dsp_address),
    .dsp_dest   (dsp_dest),
    .dsp_writes (dsp_writes),
    .dsp_jumps  (dsp_jumps),
    .dsp_spec   (dsp_spec),
    .dsp_ready  (dsp_ready),
    .delete_tag (delete_tag),
    .clear_tag  (clear_tag)
  );

  reorder_buffer #(
    .SIZE(SIZE)
  ) u_rob (
    .clock           (clock),
    .reset           (reset),
    .dsp_valid       (dsp_valid),
    .dsp_address     (dsp_address),
    .dsp_dest        (dsp_dest),
    .dsp_writes      (dsp_writes),
    .dsp_jumps       (dsp_jumps),
    .dsp_spec        (dsp_spec),
    .dsp_ready       (dsp_ready),
    .issue_valid     (issue_valid),
    .issue_tag       (issue_tag),
    .cdb_valid       (cdb_valid),
    .cdb_tag         (cdb_tag),
    .cdb_result      (cdb_result),
    .cdb_jmp_address (cdb_jmp_address),
    .head_valid      (head_valid),
    .head_address    (head_address),
    .head_dest       (head_dest),
    .head_writes     (head_writes),
    .head_jumps      (head_jumps),
    .head_result     (head_result),
    .head_jmp_address(head_jmp_address),
    .head_pop        (head_pop),
    .delete_tag      (delete_tag),
    .clear_tag       (clear_tag)
  );

  commit_unit u_commit (
    .clock           (clock),
    .reset           (reset),
    .head_valid      (head_valid),
    .head_address    (head_address),
    .head_dest       (head_dest),
    .head_writes     (head_writes),
    .head_jumps      (head_jumps),
    .head_result     (head_result),
    .head_jmp_address(head_jmp_address),
    .head_pop        (head_pop),
    .commit_valid    (commit_valid),
    .commit_address  (commit_address),
    .commit_dest     (commit_dest),
    .commit_result   (commit_result),
    .jmp_write       (jmp_write),
    .jmp_address     (jmp_address),
    .delete_tag      (delete_tag),
    .clear_tag       (clear_tag),
    .rf_addr         (rf_addr),
    .rf_data         (rf_data)
  );

endmodule

//--- rob_pkg.sv
// Shared widths, entry tag type and state encodings for the retirement path
package rob_pkg;

  // Tag width bounds the reorder buffer depth to 2**ROB_TAG_W
  localparam int ROB_TAG_W = 4;

  // Data and address paths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;

  // Architectural register file
  localparam int ARCH_REG_W = 5;
  localparam int ARCH_REGS  = 2 ** ARCH_REG_W;

  // Result word from the completion bus
  typedef logic [WORD_W-1:0] word_t;

  // Instruction address or resolved jump target
  typedef logic [ADDR_W-1:0] addr_t;

  // Register number, x0 stays zero
  typedef logic [ARCH_REG_W-1:0] arch_reg_t;

  // Reorder buffer entry index
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // Fall-through step of a not-taken jump
  localparam addr_t INSTR_BYTES = 32'd4;

  // Entry lifecycle inside the reorder buffer
  typedef enum logic [1:0] {
    WAITING,
    COMPLETED,
    IGNORE
  } entry_status_e;

  // Commit unit FSM
  // IDLE takes the head, RETIRE reports and writes back
  typedef enum logic {
    IDLE,
    RETIRE
  } commit_state_e;

endpackage

//--- tb_rob_core.sv
// Retirement subsystem testbench with stimulus table, LFSR completion order and scoreboard
`timescale 1ns/1ps

module tb_rob_core;

  import rob_pkg::*;

  localparam int SIZE  = 16;
  localparam int NROWS = 33;
  localparam int LIMIT = 40 * NROWS + 200;

  logic      clock;
  logic      reset;
  logic      in_valid;
  addr_t     in_address;
  arch_reg_t in_dest;
  logic      in_writes;
  logic      in_jumps;
  logic      in_ready;
  logic      issue_valid;
  rob_tag_t  issue_tag;
  logic      cdb_valid;
  rob_tag_t  cdb_tag;
  word_t     cdb_result;
  addr_t     cdb_jmp_address;
  logic      commit_valid;
  addr_t     commit_address;
  arch_reg_t commit_dest;
  word_t     commit_result;
  logic      jmp_write;
  addr_t     jmp_address;
  arch_reg_t rf_addr;
  word_t     rf_data;

  // Stimulus table with expected results
  addr_t     t_addr   [NROWS];
  arch_reg_t t_dest   [NROWS];
  logic      t_writes [NROWS];
  logic      t_jumps  [NROWS];
  word_t     t_result [NROWS];
  addr_t     t_target [NROWS];
  logic      t_flush  [NROWS];
  logic      t_bp     [NROWS];

  // Earliest accepted-row count before a row may complete
  int ready_after    [NROWS];
  int commits_before [NROWS];

  // Scoreboard state
  int       exp_q[$];
  int       acc_q[$];
  rob_tag_t pool_tag[$];
  int       pool_row[$];
  word_t    exp_regs [ARCH_REGS];
  int       errors;
  int       row_idx;
  int       commits_seen;
  int       total_exp;
  int       cycle;
  int       alloc_cnt;
  logic     jump_open;
  logic     taken_open;
  logic     stall_seen;
  logic     timed_out;
  int       bp_state;
  int       bp_count;
  int       stall_cnt;
  int       idle_cnt;
  logic [15:0] lfsr;

  rob_core_top #(
    .SIZE(SIZE)
  ) u_rob_core_top (
    .clock          (clock),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_address     (in_address),
    .in_dest        (in_dest),
    .in_writes      (in_writes),
    .in_jumps       (in_jumps),
    .in_ready       (in_ready),
    .issue_valid    (issue_valid),
    .issue_tag      (issue_tag),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .cdb_result     (cdb_result),
    .cdb_jmp_address(cdb_jmp_address),
    .commit_valid   (commit_valid),
    .commit_address (commit_address),
    .commit_dest    (commit_dest),
    .commit_result  (commit_result),
    .jmp_write      (jmp_write),
    .jmp_address    (jmp_address),
    .rf_addr        (rf_addr),
    .rf_data        (rf_data)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic set_row(input int i, input addr_t a, input arch_reg_t d, input logic w,
                         input logic j, input word_t res, input addr_t tgt, input logic fl,
                         input logic bp);
    t_addr[i]   = a;
    t_dest[i]   = d;
    t_writes[i] = w;
    t_jumps[i]  = j;
    t_result[i] = res;
    t_target[i] = tgt;
    t_flush[i]  = fl;
    t_bp[i]     = bp;
  endtask

  // Predict-not-taken misses when the target is not the next instruction
  function automatic logic is_taken(input int r);
    is_taken = t_jumps[r] && t_target[r] != t_addr[r] + 32'd4;
  endfunction

  // Galois LFSR stepped once per bit taken
  function automatic int rand_bits(input int nbits);
    int value;
    value = 0;
    for (int b = 0; b < nbits; b++) begin
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  task automatic fill_table();
    set_row(0, 32'h100, 5'd1, 1'b1, 1'b0, 32'h11, 32'h0, 1'b0, 1'b0);
    set_row(1, 32'h104, 5'd2, 1'b1, 1'b0, 32'h22, 32'h0, 1'b0, 1'b0);
    // x0 write must be dropped
    set_row(2, 32'h108, 5'd0, 1'b1, 1'b0, 32'hdead, 32'h0, 1'b0, 1'b0);
    // Fall-through jump lets its followers commit
    set_row(3, 32'h10c, 5'd3, 1'b0, 1'b1, 32'h0, 32'h110, 1'b0, 1'b0);
    set_row(4, 32'h110, 5'd4, 1'b1, 1'b0, 32'h44, 32'h0, 1'b0, 1'b0);
    set_row(5, 32'h114, 5'd5, 1'b1, 1'b0, 32'h55, 32'h0, 1'b0, 1'b0);
    // Back-to-back jumps hit the stall
    set_row(6, 32'h118, 5'd0, 1'b0, 1'b1, 32'h0, 32'h11c, 1'b0, 1'b0);
    set_row(7, 32'h11c, 5'd0, 1'b0, 1'b1, 32'h0, 32'h400, 1'b0, 1'b0);
    // Wrong path after the taken jump
    set_row(8, 32'h120, 5'd1, 1'b1, 1'b0, 32'hbad1, 32'h0, 1'b1, 1'b0);
    set_row(9, 32'h124, 5'd2, 1'b1, 1'b0, 32'hbad2, 32'h0, 1'b1, 1'b0);
    set_row(10, 32'h128, 5'd6, 1'b1, 1'b0, 32'hbad3, 32'h0, 1'b1, 1'b0);
    set_row(11, 32'h400, 5'd6, 1'b1, 1'b0, 32'h66, 32'h0, 1'b0, 1'b0);
    // Back-pressure block larger than the buffer
    for (int i = 12; i < 32; i++) begin
      set_row(i, 32'h404 + 32'(4 * (i - 12)), arch_reg_t'(i - 4), 1'b1, 1'b0,
              32'h1000 + 32'(i), 32'h0, 1'b0, i == 12);
    end
    set_row(32, 32'h454, 5'd1, 1'b1, 1'b0, 32'h111, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic check_regs(input string when);
    for (int i = 0; i < ARCH_REGS; i++) begin
      @(posedge clock);
      #1;
      rf_addr = arch_reg_t'(i);
      @(negedge clock);
      if (rf_data !== exp_regs[i]) begin
        errors++;
        $display("Error: rf_data[%0d] %s got %h expected %h", i, when, rf_data, exp_regs[i]);
      end
    end
  endtask

  initial begin
    int r;
    int j;
    int n;
    int k;
    int pick;
    int elig[$];

    reset           = 1'b1;
    in_valid        = 1'b0;
    in_address      = '0;
    in_dest         = '0;
    in_writes       = 1'b0;
    in_jumps        = 1'b0;
    cdb_valid       = 1'b0;
    cdb_tag         = '0;
    cdb_result      = '0;
    cdb_jmp_address = '0;
    rf_addr         = '0;
    errors          = 0;
    row_idx         = 0;
    commits_seen    = 0;
    cycle           = 0;
    alloc_cnt       = 0;
    jump_open       = 1'b0;
    taken_open      = 1'b0;
    stall_seen      = 1'b0;
    timed_out       = 1'b0;
    bp_state        = 0;
    bp_count        = 0;
    stall_cnt       = 0;
    idle_cnt        = 0;
    lfsr            = 16'd59;

    fill_table();
    for (int i = 0; i < ARCH_REGS; i++) begin
      exp_regs[i] = '0;
    end
    // Expected retirement order and drain points
    n = 0;
    for (int i = 0; i < NROWS; i++) begin
      commits_before[i] = n;
      ready_after[i]    = 0;
      if (!t_flush[i]) begin
        exp_q.push_back(i);
        n++;
      end
      if (is_taken(i)) begin
        j = i + 1;
        while (j < NROWS && t_flush[j]) begin
          j++;
        end
        ready_after[i] = j;
      end
    end
    total_exp = n;

    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    if (commit_valid !== 1'b0 || jmp_write !== 1'b0 || issue_valid !== 1'b0) begin
      errors++;
      $display("Error: after reset commit_valid %h jmp_write %h issue_valid %h expected 0",
               commit_valid, jmp_write, issue_valid);
    end
    check_regs("after reset");

    while (!(row_idx == NROWS && commits_seen == total_exp) && !timed_out) begin
      @(posedge clock);
      #1;
      cycle++;

      // Dispatch side
      in_valid = 1'b0;
      if (row_idx < NROWS) begin
        if (t_bp[row_idx] && bp_state == 0) begin
          if (commits_seen == commits_before[row_idx] && acc_q.size() == 0) begin
            idle_cnt++;
          end else begin
            idle_cnt = 0;
          end
          if (idle_cnt >= 4) begin
            bp_state = 1;
          end
        end
        // Correct path waits for the redirect
        if (!(taken_open && !t_flush[row_idx]) && !(t_bp[row_idx] && bp_state == 0)) begin
          in_valid   = 1'b1;
          in_address = t_addr[row_idx];
          in_dest    = t_dest[row_idx];
          in_writes  = t_writes[row_idx];
          in_jumps   = t_jumps[row_idx];
        end
      end

      // Completions are withheld during back-pressure
      cdb_valid = 1'b0;
      if (bp_state != 1 && pool_tag.size() > 0) begin
        pick = rand_bits(1);
        if (pick == 1) begin
          elig.delete();
          foreach (pool_row[m]) begin
            if (ready_after[pool_row[m]] <= row_idx) begin
              elig.push_back(m);
            end
          end
          if (elig.size() > 0) begin
            pick            = rand_bits(4);
            k               = elig[pick % elig.size()];
            cdb_valid       = 1'b1;
            cdb_tag         = pool_tag[k];
            cdb_result      = t_result[pool_row[k]];
            cdb_jmp_address = t_target[pool_row[k]];
            pool_tag.delete(k);
            pool_row.delete(k);
          end
        end
      end

      @(negedge clock);
      // Jump stall
      if (in_valid && in_jumps && jump_open) begin
        if (in_ready) begin
          errors++;
          $display("Jump at row %0d was accepted while an earlier jump was unresolved",
                   row_idx);
        end else begin
          stall_seen = 1'b1;
        end
      end
      // Tag assignment in dispatch order
      if (issue_valid) begin
        // Tags advance around the circular buffer
        if (issue_tag !== rob_tag_t'(alloc_cnt % SIZE)) begin
          errors++;
          $display("Error: issue_tag got %h expected %h", issue_tag,
                   rob_tag_t'(alloc_cnt % SIZE));
        end
        alloc_cnt++;
        if (acc_q.size() == 0) begin
          errors++;
          $display("issue_valid went high with no instruction dispatched");
        end else begin
          r = acc_q.pop_front();
          if (!t_flush[r]) begin
            pool_tag.push_back(issue_tag);
            pool_row.push_back(r);
          end
        end
      end
      if (jmp_write && !commit_valid) begin
        errors++;
        $display("Redirect raised without a retiring instruction");
      end
      if (commit_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected retirement at address %h", commit_address);
        end else begin
          r = exp_q.pop_front();
          commits_seen++;
          if (commit_address !== t_addr[r]) begin
            errors++;
            $display("Error: commit_address row %0d got %h expected %h", r,
                     commit_address, t_addr[r]);
          end
          if (commit_dest !== t_dest[r]) begin
            errors++;
            $display("Error: commit_dest row %0d got %h expected %h", r, commit_dest, t_dest[r]);
          end
          if (commit_result !== t_result[r]) begin
            errors++;
            $display("Error: commit_result row %0d got %h expected %h", r,
                     commit_result, t_result[r]);
          end
          if (t_writes[r] && t_dest[r] != '0) begin
            exp_regs[t_dest[r]] = t_result[r];
          end
          if (t_jumps[r]) begin
            jump_open = 1'b0;
          end
          if (is_taken(r)) begin
            taken_open = 1'b0;
            if (!jmp_write) begin
              errors++;
              $display("Taken jump at row %0d retired without a redirect", r);
            end else if (jmp_address !== t_target[r]) begin
              errors++;
              $display("Error: jmp_address row %0d got %h expected %h", r,
                       jmp_address, t_target[r]);
            end
          end else if (jmp_write) begin
            errors++;
            $display("Error: jmp_write row %0d got %h expected %h", r, jmp_write, 1'b0);
          end
        end
      end
      // Held wrong-path instruction is dropped by the flush
      if (jmp_write) begin
        while (acc_q.size() > 0) begin
          r = acc_q.pop_front();
          if (!t_flush[r]) begin
            errors++;
            $display("Row %0d was lost in a flush but is on the correct path", r);
          end
        end
      end
      if (in_valid && in_ready) begin
        acc_q.push_back(row_idx);
        if (t_jumps[row_idx]) begin
          jump_open = 1'b1;
          if (is_taken(row_idx)) begin
            taken_open = 1'b1;
          end
        end
        if (bp_state == 1) begin
          bp_count++;
        end
        row_idx++;
      end
      // Full buffer plus one held entry
      if (bp_state == 1) begin
        if (in_valid && !in_ready) begin
          stall_cnt++;
        end else begin
          stall_cnt = 0;
        end
        if (stall_cnt == 4) begin
          if (bp_count != SIZE + 1) begin
            errors++;
            $display("Error: in_ready accepts before stall got %h expected %h",
                     bp_count, SIZE + 1);
          end
          bp_state = 2;
        end
      end
      if (cycle >= LIMIT) begin
        timed_out = 1'b1;
        errors++;
        $display("Timeout after %0d cycles with %0d of %0d retirements seen",
                 cycle, commits_seen, total_exp);
      end
    end

    @(posedge clock);
    #1;
    in_valid  = 1'b0;
    cdb_valid = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    if (!stall_seen) begin
      errors++;
      $display("A second jump was never held back by the jump stall");
    end
    if (bp_state != 2) begin
      errors++;
      $display("The back-pressure stall was never observed");
    end
    check_regs("at end");

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
